// File: all.f
+incdir+include
source/screen_geometry_pkg.sv
source/entity_pkg.sv
source/entity_scan_sequencer.sv
source/tile_hit_detector.sv
source/tile_entity_latch.sv
source/entity_tile_unit.sv
dv/entity_tile_unit_tb.sv

// File: include/tile_vectors.svh
// vector table for the entity tile unit testbench, fixed rows and the pixel row sweep
`ifndef TILE_VECTORS_SVH
`define TILE_VECTORS_SVH

// unused slot, id all ones at tile row 0 col 0
localparam entity_t empty_slot = 14'h3c00;

// columns are name, slot 1 to slot 9, counter_v, boundary counter_h, expected result
// slot word is {id, orient, tile row, tile col}
// result is {pixel row, id, orient}
// boundary 80 looks ahead to x 120, tile col 3
task automatic fill_vector_table();
    int k;
    // id 3 orient 2 at row 3 col 3, y 130 is offset 10 in the tile
    add_vector("single_hit", empty_slot, empty_slot, empty_slot, 14'h0e33, empty_slot,
               empty_slot, empty_slot, empty_slot, empty_slot, 10'd130, 10'd80, 9'h08e);
    // entity two columns off
    add_vector("miss_all", empty_slot, 14'h1535, empty_slot, empty_slot, empty_slot,
               empty_slot, empty_slot, empty_slot, empty_slot, 10'd130, 10'd80, 9'h1ff);
    // covering slot carries the unused id
    add_vector("unused_cover", 14'h3f33, empty_slot, empty_slot, empty_slot, empty_slot,
               empty_slot, empty_slot, empty_slot, empty_slot, 10'd130, 10'd80, 9'h1ff);
    // slots 2, 6 and 9 all cover, slot 2 wins
    add_vector("lowest_slot_wins", empty_slot, 14'h1d33, empty_slot, empty_slot, empty_slot,
               14'h0833, empty_slot, empty_slot, 14'h2733, 10'd130, 10'd80, 9'h09d);
    // unused slot 1 skipped, slot 3 beats slot 5
    add_vector("unused_skipped", 14'h3f33, empty_slot, 14'h1233, empty_slot, 14'h1833,
               empty_slot, empty_slot, empty_slot, empty_slot, 10'd130, 10'd80, 9'h092);
    // y 240 is the first line below tile row 5
    add_vector("row_edge", empty_slot, empty_slot, empty_slot, empty_slot, empty_slot,
               empty_slot, empty_slot, 14'h295a, empty_slot, 10'd240, 10'd360, 9'h1ff);
    // lookahead x 360 is one column left of col 10
    add_vector("col_edge", empty_slot, empty_slot, empty_slot, empty_slot, empty_slot,
               empty_slot, empty_slot, 14'h295a, empty_slot, 10'd220, 10'd320, 9'h1ff);
    // id 10 orient 1 at row 5 col 10, y walks 200 to 239
    // offset 5k plus k mod 5 stays inside pixel row k
    for (k = 0; k < 8; k++) begin
        add_vector($sformatf("row_sweep_%0d", k), empty_slot, empty_slot, empty_slot,
                   empty_slot, empty_slot, empty_slot, empty_slot, 14'h295a, empty_slot,
                   pixel_t'(200 + 5 * k + k % 5), 10'd360,
                   {pixel_row_t'(k), 4'ha, 2'b01});
    end
endtask

`endif

// File: dv/entity_tile_unit_tb.sv
// entity tile unit testbench with clock, reset, vector table loop, random row, checks and report
`timescale 1ns/100ps

module entity_tile_unit_tb
    import screen_geometry_pkg::*;
    import entity_pkg::*;
();

    localparam int upscale_factor = 5;
    localparam int tile_len       = TILE_SIZE * upscale_factor;
    localparam int line_pixels    = SCREEN_TILES_H * tile_len;
    localparam int frame_lines    = SCREEN_TILES_V * tile_len;
    localparam int max_vectors    = 16;
    localparam int wait_limit     = 2000;

    logic         clk = 1'b0;
    logic         reset;
    pixel_t       counter_h = '0;
    pixel_t       counter_v;
    entity_t      entity_1;
    entity_t      entity_2;
    entity_t      entity_3;
    entity_t      entity_4;
    entity_t      entity_5;
    entity_t      entity_6;
    entity_t      entity_7;
    entity_t      entity_8;
    entity_t      entity_9;
    tile_entity_t out_entity;

    // vector table, slot index 0 is slot 1
    string        vec_name     [max_vectors];
    entity_t      vec_slot     [max_vectors][ENTITY_SLOTS];
    pixel_t       vec_v        [max_vectors];
    pixel_t       vec_h        [max_vectors];
    tile_entity_t vec_expected [max_vectors];
    int           vector_count;
    int           pass_count;
    int           error_count;
    logic         timed_out;
    int           seed;
    int           idx;

    entity_tile_unit #(
        .upscale_factor (upscale_factor)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .counter_h  (counter_h),
        .counter_v  (counter_v),
        .entity_1   (entity_1),
        .entity_2   (entity_2),
        .entity_3   (entity_3),
        .entity_4   (entity_4),
        .entity_5   (entity_5),
        .entity_6   (entity_6),
        .entity_7   (entity_7),
        .entity_8   (entity_8),
        .entity_9   (entity_9),
        .out_entity (out_entity)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // horizontal scan counter, one pixel per clock, wraps at line end
    always @(posedge clk) begin
        #1;
        if (counter_h == pixel_t'(line_pixels - 1)) begin
            counter_h = '0;
        end else begin
            counter_h = counter_h + 1'b1;
        end
    end

    task automatic add_vector(input string name,
                              input entity_t s1, s2, s3, s4, s5, s6, s7, s8, s9,
                              input pixel_t line_v, input pixel_t boundary_h,
                              input tile_entity_t expected);
        vec_name[vector_count]     = name;
        vec_slot[vector_count][0]  = s1;
        vec_slot[vector_count][1]  = s2;
        vec_slot[vector_count][2]  = s3;
        vec_slot[vector_count][3]  = s4;
        vec_slot[vector_count][4]  = s5;
        vec_slot[vector_count][5]  = s6;
        vec_slot[vector_count][6]  = s7;
        vec_slot[vector_count][7]  = s8;
        vec_slot[vector_count][8]  = s9;
        vec_v[vector_count]        = line_v;
        vec_h[vector_count]        = boundary_h;
        vec_expected[vector_count] = expected;
        vector_count++;
    endtask

    `include "tile_vectors.svh"

    // expected result straight from the tile rules
    // slot 1 searched first, first valid cover wins
    function automatic tile_entity_t reference_tile_entity(input int row_idx);
        int           look_h;
        int           look_v;
        int           org_h;
        int           org_v;
        int           s;
        logic         found;
        entity_t      word;
        tile_entity_t result;
        result = NO_TILE_ENTITY;
        found  = 1'b0;
        look_h = int'(vec_h[row_idx]) + tile_len;
        look_v = int'(vec_v[row_idx]);
        for (s = 0; s < ENTITY_SLOTS; s++) begin
            word  = vec_slot[row_idx][s];
            org_h = int'(word[3:0]) * tile_len;
            org_v = int'(word[7:4]) * tile_len;
            if (!found && word[13:10] != NO_ENTITY_ID
                    && look_h >= org_h && look_h < org_h + tile_len
                    && look_v >= org_v && look_v < org_v + tile_len) begin
                found  = 1'b1;
                result = {pixel_row_t'((look_v - org_v) / upscale_factor),
                          word[13:10], word[9:8]};
            end
        end
        return result;
    endfunction

    // random row, about half the slots placed on the lookahead tile
    task automatic build_random_vector();
        int          point_col;
        int          point_row;
        int          s;
        tile_coord_t col;
        tile_coord_t row;
        vec_name[vector_count] = "random_slots";
        vec_h[vector_count] = pixel_t'(tile_len * ($unsigned($random(seed))
                                                  % (SCREEN_TILES_H - 1)));
        vec_v[vector_count] = pixel_t'($unsigned($random(seed)) % frame_lines);
        point_col = int'(vec_h[vector_count]) / tile_len + 1;
        point_row = int'(vec_v[vector_count]) / tile_len;
        for (s = 0; s < ENTITY_SLOTS; s++) begin
            if ($random(seed) & 1) begin
                col = tile_coord_t'(point_col);
                row = tile_coord_t'(point_row);
            end else begin
                col = tile_coord_t'($random(seed));
                row = tile_coord_t'($unsigned($random(seed)) % SCREEN_TILES_V);
            end
            // any id, unused one included
            vec_slot[vector_count][s] = {entity_id_t'($random(seed)),
                                         orient_t'($random(seed)), row, col};
        end
        vec_expected[vector_count] = reference_tile_entity(vector_count);
        vector_count++;
    endtask

    // inputs change 1 ns after the clock edge
    task automatic apply_vector(input int row_idx);
        @(posedge clk);
        #1;
        entity_1  = vec_slot[row_idx][0];
        entity_2  = vec_slot[row_idx][1];
        entity_3  = vec_slot[row_idx][2];
        entity_4  = vec_slot[row_idx][3];
        entity_5  = vec_slot[row_idx][4];
        entity_6  = vec_slot[row_idx][5];
        entity_7  = vec_slot[row_idx][6];
        entity_8  = vec_slot[row_idx][7];
        entity_9  = vec_slot[row_idx][8];
        counter_v = vec_v[row_idx];
    endtask

    // returns at the edge that ends the cycle with counter_h at target
    task automatic wait_for_counter(input pixel_t target);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (counter_h != target && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (counter_h != target) begin
            $display("timeout: counter_h did not reach %0d within %0d cycles",
                     target, wait_limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_tile_entity(input string name, input tile_entity_t expected,
                                     input tile_entity_t actual);
        if (actual === expected) begin
            pass_count++;
            $display("PASS %s out_entity %03h", name, actual);
        end else begin
            error_count++;
            $display("FAIL %s expected %03h actual %03h", name, expected, actual);
        end
    endtask

    task automatic check_idle_output(input string name, input tile_entity_t actual);
        if (actual === NO_TILE_ENTITY) begin
            pass_count++;
            $display("PASS %s out_entity %03h", name, actual);
        end else begin
            error_count++;
            $display("FAIL %s expected %03h actual %03h", name, NO_TILE_ENTITY, actual);
        end
    endtask

    initial begin
        seed         = 32'hc9f8_bb08;
        vector_count = 0;
        pass_count   = 0;
        error_count  = 0;
        timed_out    = 1'b0;
        reset        = 1'b0;
        counter_v    = '0;
        entity_1     = empty_slot;
        entity_2     = empty_slot;
        entity_3     = empty_slot;
        entity_4     = empty_slot;
        entity_5     = empty_slot;
        entity_6     = empty_slot;
        entity_7     = empty_slot;
        entity_8     = empty_slot;
        entity_9     = empty_slot;
        fill_vector_table();
        build_random_vector();

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;
        @(negedge clk);
        check_idle_output("reset_value", out_entity);

        // first scan publishes the cleared holder
        wait_for_counter(pixel_t'(tile_len));
        if (!timed_out) begin
            repeat (5) @(posedge clk);
            @(negedge clk);
            check_idle_output("first_scan_start", out_entity);
        end

        // scan at the row boundary, result out at the boundary after
        for (idx = 0; idx < vector_count && !timed_out; idx++) begin
            apply_vector(idx);
            wait_for_counter(vec_h[idx]);
            if (!timed_out) begin
                wait_for_counter(pixel_t'((int'(vec_h[idx]) + tile_len) % line_pixels));
            end
            if (!timed_out) begin
                repeat (5) @(posedge clk);
                @(negedge clk);
                check_tile_entity(vec_name[idx], vec_expected[idx], out_entity);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 pass_count + error_count, pass_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : entity_tile_unit_tb

// File: run_sim.sh
#!/usr/bin/env bash
# build the entity tile unit testbench with Verilator and run it
# exit status is 0 only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module entity_tile_unit_tb -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: source/entity_pkg.sv
// entity package: slot word, id, orientation, tile result, slot count, scan FSM states
package entity_pkg;

    // entity slot word
    // [13:10] id, [9:8] orientation, [7:4] tile row, [3:0] tile column
    typedef logic [13:0] entity_t;

    typedef logic [3:0] entity_id_t;
    typedef logic [1:0] orient_t;

    // per-tile result
    // [8:6] pixel row, [5:2] id, [1:0] orientation
    typedef logic [8:0] tile_entity_t;

    // slot counter, counts down from the slot count to 1
    typedef logic [3:0] slot_index_t;

    // slot is unused when its id is all ones
    localparam entity_id_t NO_ENTITY_ID = 4'hf;

    // nothing covers the lookahead point
    localparam tile_entity_t NO_TILE_ENTITY = 9'h1ff;

    localparam int ENTITY_SLOTS = 9;

    // scan sequencer states
    typedef enum logic [0:0] {
        IDLE,
        SCANNING
    } scan_state_t;

    // field extraction from a slot word
    function automatic entity_id_t entity_id(input entity_t ent);
        return ent[13:10];
    endfunction

    function automatic orient_t entity_orient(input entity_t ent);
        return ent[9:8];
    endfunction

endpackage : entity_pkg

// File: source/entity_scan_sequencer.sv
// entity scan sequencer: tile boundary detect, lookahead point, slot scan FSM and slot mux
`timescale 1ns/100ps

module entity_scan_sequencer
    import screen_geometry_pkg::*;
    import entity_pkg::*;
#(
    parameter int upscale_factor = 5,
    parameter int tile_len_pixel = 40
) (
    input  logic    clk,
    input  logic    reset,
    input  pixel_t  counter_h,
    input  pixel_t  counter_v,
    input  entity_t entity_1,
    input  entity_t entity_2,
    input  entity_t entity_3,
    input  entity_t entity_4,
    input  entity_t entity_5,
    input  entity_t entity_6,
    input  entity_t entity_7,
    input  entity_t entity_8,
    input  entity_t entity_9,
    output entity_t slot_entity,
    output logic    slot_valid,
    output logic    scan_start,
    output pixel_t  point_h,
    output pixel_t  point_v
);

    // source pixels per tile, a power of two
    localparam int tile_src_pixels = tile_len_pixel / upscale_factor;

    scan_state_t state;
    slot_index_t slot_idx;
    logic        on_boundary;
    logic        start_scan;

    // boundary = counter on a whole upscaled pixel that also starts a source tile
    // the second test is only a low-bit mask for an 8 pixel tile
    assign on_boundary = ((counter_h % upscale_factor) == 0)
                      && (((counter_h / upscale_factor) % tile_src_pixels) == 0);

    // boundaries during a scan are ignored, next one is a full tile away anyway
    assign start_scan = (state == IDLE) && on_boundary;

    // slot 9 first, slot 1 last
    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= IDLE;
            slot_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_scan) begin
                        state    <= SCANNING;
                        slot_idx <= slot_index_t'(ENTITY_SLOTS);
                    end
                end
                SCANNING: begin
                    // slot 1 presented this cycle, scan done
                    if (slot_idx == slot_index_t'(1)) begin
                        state <= IDLE;
                    end
                    slot_idx <= slot_idx - 1'b1;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // lookahead point, one tile right on the same line
    // held steady for the whole scan
    always_ff @(posedge clk) begin
        if (start_scan) begin
            point_h <= pixel_t'(counter_h + tile_len_pixel);
            point_v <= counter_v;
        end
    end

    assign slot_valid = (state == SCANNING);

    // first slot of the scan marks the new scan for the latch
    assign scan_start = (state == SCANNING) && (slot_idx == slot_index_t'(ENTITY_SLOTS));

    // slot mux
    always_comb begin
        case (slot_idx)
            4'd1:    slot_entity = entity_1;
            4'd2:    slot_entity = entity_2;
            4'd3:    slot_entity = entity_3;
            4'd4:    slot_entity = entity_4;
            4'd5:    slot_entity = entity_5;
            4'd6:    slot_entity = entity_6;
            4'd7:    slot_entity = entity_7;
            4'd8:    slot_entity = entity_8;
            4'd9:    slot_entity = entity_9;
            // unused slot word when idle
            default: slot_entity = {NO_ENTITY_ID, 10'd0};
        endcase
    end

endmodule : entity_scan_sequencer

// File: source/entity_tile_unit.sv
// entity tile unit top: scan sequencer, hit detector and output latch
`timescale 1ns/100ps

module entity_tile_unit
    import screen_geometry_pkg::*;
    import entity_pkg::*;
#(
    parameter int upscale_factor = 5
) (
    input  logic         clk,
    input  logic         reset,
    input  pixel_t       counter_h,
    input  pixel_t       counter_v,
    input  entity_t      entity_1,
    input  entity_t      entity_2,
    input  entity_t      entity_3,
    input  entity_t      entity_4,
    input  entity_t      entity_5,
    input  entity_t      entity_6,
    input  entity_t      entity_7,
    input  entity_t      entity_8,
    input  entity_t      entity_9,
    output tile_entity_t out_entity
);

    // tile edge on screen, 40 pixels at upscale 5
    localparam int tile_len_pixel = TILE_SIZE * upscale_factor;

    entity_t      slot_entity;
    logic         slot_valid;
    logic         scan_start;
    pixel_t       point_h;
    pixel_t       point_v;
    logic         hit_valid;
    tile_entity_t hit_entity;

    // boundary detect and slot scan
    entity_scan_sequencer #(
        .upscale_factor (upscale_factor),
        .tile_len_pixel (tile_len_pixel)
    ) u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .counter_h   (counter_h),
        .counter_v   (counter_v),
        .entity_1    (entity_1),
        .entity_2    (entity_2),
        .entity_3    (entity_3),
        .entity_4    (entity_4),
        .entity_5    (entity_5),
        .entity_6    (entity_6),
        .entity_7    (entity_7),
        .entity_8    (entity_8),
        .entity_9    (entity_9),
        .slot_entity (slot_entity),
        .slot_valid  (slot_valid),
        .scan_start  (scan_start),
        .point_h     (point_h),
        .point_v     (point_v)
    );

    // two cycles from slot to hit
    tile_hit_detector #(
        .upscale_factor (upscale_factor),
        .tile_len_pixel (tile_len_pixel)
    ) u_detector (
        .clk         (clk),
        .reset       (reset),
        .slot_entity (slot_entity),
        .slot_valid  (slot_valid),
        .point_h     (point_h),
        .point_v     (point_v),
        .hit_valid   (hit_valid),
        .hit_entity  (hit_entity)
    );

    // result of a scan shows up at the following boundary
    tile_entity_latch u_latch (
        .clk        (clk),
        .reset      (reset),
        .scan_start (scan_start),
        .hit_valid  (hit_valid),
        .hit_entity (hit_entity),
        .out_entity (out_entity)
    );

endmodule : entity_tile_unit

// File: source/screen_geometry_pkg.sv
// screen geometry package: pixel, tile and row types, tile size and screen size in tiles
package screen_geometry_pkg;

    // scan counter or pixel coordinate
    // wide enough for the 640 pixel line plus one tile of lookahead
    typedef logic [9:0] pixel_t;

    // tile column or tile row index
    // column in the low nibble of an entity location, row in the high nibble
    typedef logic [3:0] tile_coord_t;

    // pixel row inside a tile, after the upscale is divided out
    typedef logic [2:0] pixel_row_t;

    // source tile edge in pixels, before upscaling
    localparam int TILE_SIZE = 8;

    // visible screen in tiles
    localparam int SCREEN_TILES_H = 16;
    localparam int SCREEN_TILES_V = 12;

endpackage : screen_geometry_pkg

// File: source/tile_entity_latch.sv
// tile entity latch: priority holder for the running scan and per-tile output register
`timescale 1ns/100ps

module tile_entity_latch
    import entity_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         scan_start,
    input  logic         hit_valid,
    input  tile_entity_t hit_entity,
    output tile_entity_t out_entity
);

    // last hit of the running scan
    tile_entity_t holder;

    // slots arrive 9 down to 1, so a later hit overwrites an earlier one
    // lowest numbered covering slot wins
    // hits of one scan all land after its scan_start, never on it
    always_ff @(posedge clk) begin
        if (!reset) begin
            holder     <= NO_TILE_ENTITY;
            out_entity <= NO_TILE_ENTITY;
        end else if (scan_start) begin
            // publish previous scan, start a fresh one
            out_entity <= holder;
            holder     <= NO_TILE_ENTITY;
        end else if (hit_valid) begin
            holder <= hit_entity;
        end
    end

endmodule : tile_entity_latch

// File: source/tile_hit_detector.sv
// tile hit detector: two-stage pipeline from a slot word to a hit with its pixel row
`timescale 1ns/100ps

module tile_hit_detector
    import screen_geometry_pkg::*;
    import entity_pkg::*;
#(
    parameter int upscale_factor = 5,
    parameter int tile_len_pixel = 40
) (
    input  logic         clk,
    input  logic         reset,
    input  entity_t      slot_entity,
    input  logic         slot_valid,
    input  pixel_t       point_h,
    input  pixel_t       point_v,
    output logic         hit_valid,
    output tile_entity_t hit_entity
);

    tile_coord_t slot_col;
    tile_coord_t slot_row;

    // stage one registers
    logic        s1_valid;
    pixel_t      s1_origin_h;
    pixel_t      s1_origin_v;
    entity_id_t  s1_id;
    orient_t     s1_orient;

    // stage two terms
    logic        in_h;
    logic        in_v;
    logic        is_hit;
    pixel_t      v_offset;
    pixel_row_t  pixel_row;

    // tile location, column low nibble, row high nibble
    assign slot_col = slot_entity[3:0];
    assign slot_row = slot_entity[7:4];

    // stage one valid
    always_ff @(posedge clk) begin
        if (!reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= slot_valid;
        end
    end

    // stage one: tile origin in screen pixels, id and orientation carried along
    always_ff @(posedge clk) begin
        s1_origin_h <= pixel_t'(slot_col * tile_len_pixel);
        s1_origin_v <= pixel_t'(slot_row * tile_len_pixel);
        s1_id       <= entity_id(slot_entity);
        s1_orient   <= entity_orient(slot_entity);
    end

    // half-open span on both axes
    assign in_h = (point_h >= s1_origin_h) && (point_h < s1_origin_h + tile_len_pixel);
    assign in_v = (point_v >= s1_origin_v) && (point_v < s1_origin_v + tile_len_pixel);

    // unused slots never hit, whatever their location
    assign is_hit = in_h && in_v && (s1_id != NO_ENTITY_ID);

    // row inside the tile, back in source pixels
    // offset < tile_len_pixel on a hit, so the quotient fits
    assign v_offset  = point_v - s1_origin_v;
    assign pixel_row = pixel_row_t'(v_offset / upscale_factor);

    // stage two valid, misses dropped here
    always_ff @(posedge clk) begin
        if (!reset) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= s1_valid && is_hit;
        end
    end

    // stage two payload
    always_ff @(posedge clk) begin
        hit_entity <= {pixel_row, s1_id, s1_orient};
    end

endmodule : tile_hit_detector
